// File: verilog/ieu_pkg.sv
// Integer execute stage shared definitions
// Widths, opcode and state encodings, and the structs that carry an issued
// operation, a data bus command and a register-file write

package ieu_pkg;

   localparam int DATA_W = 32;   // Operand and data width
   localparam int REG_AW = 5;    // Register address width
   localparam int PC_W   = 30;   // Word-aligned pc

   typedef enum logic [3:0] {
      OPC_ADD,
      OPC_SUB,
      OPC_CMP_EQ,
      OPC_CMP_LT,
      OPC_CMP_LTU,
      OPC_AND,
      OPC_OR,
      OPC_XOR,
      OPC_SLL,
      OPC_SRL,
      OPC_SRA,
      OPC_LOAD,
      OPC_STORE,
      OPC_JMPREL,
      OPC_JMPFAR
   } ieu_opc_e;

   typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

   typedef enum logic [1:0] {MEM_IDLE, MEM_CMD, MEM_RESP, MEM_WB} mem_state_e;

   typedef struct packed {
      ieu_opc_e            opc;
      logic [DATA_W-1:0]   operand_1;
      logic [DATA_W-1:0]   operand_2;
      logic [DATA_W-1:0]   operand_3;    // Store data
      logic                wb;           // Writes a register
      logic [REG_AW-1:0]   wb_addr;
      logic [PC_W-1:0]     pc;
      logic                pred_taken;   // Predicted direction of a relative branch
      logic [PC_W-1:0]     pred_tgt;
      mem_size_e           size;
      logic                sign_ext;
   } ieu_op_t;

   typedef struct packed {
      logic [DATA_W-1:0]   addr;         // Byte address
      mem_size_e           size;
      logic                we;
      logic [DATA_W-1:0]   wdata;
   } dbus_cmd_t;

   typedef struct packed {
      logic [REG_AW-1:0]   addr;
      logic [DATA_W-1:0]   data;
   } wb_req_t;

endpackage

// File: verilog/ieu_arith.sv
// Arithmetic unit of the execute stage
// Add, subtract and the three compares, plus the link address of a far jump.
// Holds the condition flag loaded by every accepted compare

`timescale 1ns/1ps

module ieu_arith (
   input  logic                       clk,
   input  logic                       rst_n,
   input  ieu_pkg::ieu_op_t           op,
   input  logic                       accept,
   output logic [ieu_pkg::DATA_W-1:0] result,
   output logic                       cc
);
   import ieu_pkg::*;

   logic [DATA_W-1:0] sum;
   logic [DATA_W-1:0] diff;
   logic [PC_W-1:0]   pc_next;
   logic [DATA_W-1:0] link;
   logic              cmp_eq;
   logic              cmp_lt;
   logic              cmp_ltu;
   logic              cmp_flag;
   logic              is_cmp;

   assign sum     = op.operand_1 + op.operand_2;
   assign diff    = op.operand_1 - op.operand_2;
   assign cmp_eq  = (op.operand_1 == op.operand_2);
   assign cmp_lt  = ($signed(op.operand_1) < $signed(op.operand_2));
   assign cmp_ltu = (op.operand_1 < op.operand_2);

   // Instruction after the jump, as a byte address
   assign pc_next = op.pc + 1'b1;
   assign link    = {pc_next, 2'b00};

   always_comb begin
      is_cmp   = 1'b1;
      cmp_flag = 1'b0;
      case (op.opc)
         OPC_CMP_EQ:  cmp_flag = cmp_eq;
         OPC_CMP_LT:  cmp_flag = cmp_lt;
         OPC_CMP_LTU: cmp_flag = cmp_ltu;
         default:     is_cmp = 1'b0;
      endcase
   end

   always_comb begin
      case (op.opc)
         OPC_SUB:     result = diff;
         OPC_CMP_EQ,
         OPC_CMP_LT,
         OPC_CMP_LTU: result = {{(DATA_W-1){1'b0}}, cmp_flag};   // 0 or 1
         OPC_JMPFAR:  result = link;
         default:     result = sum;
      endcase
   end

   // Branches read this on the cycle after the compare
   always_ff @(posedge clk) begin
      if (!rst_n)
         cc <= 1'b0;
      else if (accept && is_cmp)
         cc <= cmp_flag;
   end

endmodule

// File: verilog/ieu_logic.sv
// Logic unit of the execute stage
// Bitwise and, or, xor and a barrel shifter for the three shifts.
// Purely combinational

`timescale 1ns/1ps

module ieu_logic (
   input  ieu_pkg::ieu_op_t           op,
   output logic [ieu_pkg::DATA_W-1:0] result
);
   import ieu_pkg::*;

   logic [4:0]        shamt;
   logic [DATA_W-1:0] shl;
   logic [DATA_W-1:0] shr_l;
   logic [DATA_W-1:0] shr_a;

   assign shamt = op.operand_2[4:0];   // Low five bits only

   assign shl   = op.operand_1 << shamt;
   assign shr_l = op.operand_1 >> shamt;

   // Fills with the sign bit
   assign shr_a = $signed(op.operand_1) >>> shamt;

   always_comb begin
      case (op.opc)
         OPC_AND: begin
            result = op.operand_1 & op.operand_2;
         end
         OPC_OR: begin
            result = op.operand_1 | op.operand_2;
         end
         OPC_XOR: begin
            result = op.operand_1 ^ op.operand_2;
         end
         OPC_SLL: begin
            result = shl;
         end
         OPC_SRL: begin
            result = shr_l;
         end
         OPC_SRA: begin
            result = shr_a;
         end
         default: begin
            result = '0;   // Not a logic op
         end
      endcase
   end

endmodule

// File: verilog/ieu_mem.sv
// Load/store sequencer
// Runs one data bus access at a time: command, response, then a write
// request for the loaded value, zero or sign extended by access size

`timescale 1ns/1ps

module ieu_mem (
   input  logic                       clk,
   input  logic                       rst_n,
   input  ieu_pkg::ieu_op_t           op,
   input  logic                       accept,
   input  logic                       dbus_cmd_ready,
   input  logic                       dbus_valid,
   input  logic [ieu_pkg::DATA_W-1:0] dbus_dout,
   input  logic                       mem_wb_grant,
   output logic                       dbus_cmd_valid,
   output ieu_pkg::dbus_cmd_t         dbus_cmd,
   output logic                       dbus_ready,
   output logic                       mem_busy,
   output logic                       mem_wb_valid,
   output ieu_pkg::wb_req_t           mem_wb
);
   import ieu_pkg::*;

   mem_state_e        state_q;
   mem_state_e        state_d;
   dbus_cmd_t         cmd_q;
   wb_req_t           wb_q;
   logic              ld_wb_q;     // Load has a destination register
   logic              ld_sext_q;
   logic              is_mem;
   logic              start;
   logic [DATA_W-1:0] ld_ext;

   assign is_mem = (op.opc == OPC_LOAD) || (op.opc == OPC_STORE);
   assign start  = (state_q == MEM_IDLE) && accept && is_mem;

   // Bus returns load data right-aligned
   always_comb begin
      case (cmd_q.size)
         SIZE_BYTE: ld_ext = {{(DATA_W-8){ld_sext_q & dbus_dout[7]}}, dbus_dout[7:0]};
         SIZE_HALF: ld_ext = {{(DATA_W-16){ld_sext_q & dbus_dout[15]}}, dbus_dout[15:0]};
         default:   ld_ext = dbus_dout;
      endcase
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         MEM_IDLE: begin
            if (start)
               state_d = MEM_CMD;
         end
         MEM_CMD: begin
            if (dbus_cmd_ready)
               state_d = cmd_q.we ? MEM_IDLE : MEM_RESP;   // Store is done at transfer
         end
         MEM_RESP: begin
            if (dbus_valid)
               state_d = ld_wb_q ? MEM_WB : MEM_IDLE;
         end
         MEM_WB: begin
            if (mem_wb_grant)
               state_d = MEM_IDLE;
         end
         default: begin
            state_d = MEM_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         state_q <= MEM_IDLE;
      else
         state_q <= state_d;
   end

   // Command fields stay put while the bus stalls
   always_ff @(posedge clk) begin
      if (start) begin
         cmd_q.addr  <= op.operand_1 + op.operand_2;
         cmd_q.size  <= op.size;
         cmd_q.we    <= (op.opc == OPC_STORE);
         cmd_q.wdata <= op.operand_3;
         ld_wb_q     <= op.wb;
         ld_sext_q   <= op.sign_ext;
         wb_q.addr   <= op.wb_addr;
      end
      if ((state_q == MEM_RESP) && dbus_valid)
         wb_q.data <= ld_ext;
   end

   assign dbus_cmd_valid = (state_q == MEM_CMD);
   assign dbus_cmd       = cmd_q;
   assign dbus_ready     = (state_q == MEM_RESP);
   assign mem_busy       = (state_q != MEM_IDLE);
   assign mem_wb_valid   = (state_q == MEM_WB);
   assign mem_wb         = wb_q;

endmodule

// File: verilog/ieu_branch.sv
// Branch check
// Compares the predicted outcome of relative branches and far jumps with the
// real one, raises a flush on a mismatch and holds it with its target until
// the fetch side acknowledges

`timescale 1ns/1ps

module ieu_branch (
   input  logic                     clk,
   input  logic                     rst_n,
   input  ieu_pkg::ieu_op_t         op,
   input  logic                     accept,
   input  logic                     cc,
   input  logic                     flush_ack,
   output logic                     specul_flush,
   output logic                     flush_hold,
   output logic [ieu_pkg::PC_W-1:0] flush_tgt,
   output logic                     bpu_wb,
   output logic                     bpu_hit
);
   import ieu_pkg::*;

   logic            is_rel;
   logic            is_far;
   logic            rel_mis;
   logic            far_mis;
   logic            mismatch;
   logic            flush_now;
   logic            hold_q;
   logic [PC_W-1:0] pc_next;
   logic [PC_W-1:0] rel_tgt;
   logic [PC_W-1:0] far_tgt;
   logic [PC_W-1:0] tgt_now;
   logic [PC_W-1:0] tgt_q;

   assign is_rel = (op.opc == OPC_JMPREL);
   assign is_far = (op.opc == OPC_JMPFAR);

   assign pc_next = op.pc + 1'b1;
   assign rel_tgt = cc ? op.pred_tgt : pc_next;         // Taken or fall-through
   assign far_tgt = op.operand_1[DATA_W-1:DATA_W-PC_W]; // Register target, word address

   assign rel_mis  = (op.pred_taken != cc);
   assign far_mis  = (op.pred_tgt != far_tgt);
   assign mismatch = (is_rel && rel_mis) || (is_far && far_mis);

   assign flush_now = accept && mismatch;
   assign tgt_now   = is_rel ? rel_tgt : far_tgt;

   // Cleared by the ack, including an ack in the accepting cycle
   always_ff @(posedge clk) begin
      if (!rst_n)
         hold_q <= 1'b0;
      else
         hold_q <= (flush_now || hold_q) && !flush_ack;
   end

   always_ff @(posedge clk) begin
      if (flush_now)
         tgt_q <= tgt_now;
   end

   assign specul_flush = flush_now || hold_q;
   assign flush_hold   = hold_q;
   assign flush_tgt    = hold_q ? tgt_q : tgt_now;

   // Predictor update on every jump
   assign bpu_wb  = accept && (is_rel || is_far);
   assign bpu_hit = !mismatch;

endmodule

// File: verilog/ieu_wb_arb.sv
// Writeback arbiter and issue control
// Registers the ALU result, shares the register-file write port between the
// load result (first) and the ALU result, and forms issue ready and accept

`timescale 1ns/1ps

module ieu_wb_arb (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       in_valid,
   input  logic                       accept_ok,
   input  ieu_pkg::ieu_op_t           op,
   input  logic [ieu_pkg::DATA_W-1:0] arith_result,
   input  logic [ieu_pkg::DATA_W-1:0] logic_result,
   input  logic                       mem_busy,
   input  logic                       flush_hold,
   input  logic                       mem_wb_valid,
   input  ieu_pkg::wb_req_t           mem_wb,
   output logic                       in_ready,
   output logic                       accept,
   output logic                       mem_wb_grant,
   output logic                       regf_we,
   output ieu_pkg::wb_req_t           regf_wr
);
   import ieu_pkg::*;

   logic    is_mem;
   logic    is_logic;
   logic    alu_load;
   logic    alu_vld_q;
   logic    alu_grant;
   wb_req_t alu_req_q;

   assign is_mem   = (op.opc == OPC_LOAD) || (op.opc == OPC_STORE);
   assign is_logic = (op.opc inside {OPC_AND, OPC_OR, OPC_XOR, OPC_SLL, OPC_SRL, OPC_SRA});

   // Load result always wins the port
   assign mem_wb_grant = mem_wb_valid;
   assign alu_grant    = alu_vld_q && !mem_wb_valid;

   assign in_ready = !flush_hold
                     && (!alu_vld_q || alu_grant)
                     && !(is_mem && mem_busy);
   assign accept   = in_valid && in_ready && accept_ok;
   assign alu_load = accept && !is_mem && op.wb;   // Includes links and compares

   always_ff @(posedge clk) begin
      if (!rst_n)
         alu_vld_q <= 1'b0;
      else if (alu_load)
         alu_vld_q <= 1'b1;
      else if (alu_grant)
         alu_vld_q <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (alu_load) begin
         alu_req_q.addr <= op.wb_addr;
         alu_req_q.data <= is_logic ? logic_result : arith_result;
      end
   end

   assign regf_we = mem_wb_valid || alu_vld_q;
   assign regf_wr = mem_wb_valid ? mem_wb : alu_req_q;

endmodule

// File: verilog/ieu_top.sv
// Integer execute stage
// Takes one decoded operation per cycle and fans it out to the arithmetic,
// logic, memory and branch units, with a shared register-file write port

`timescale 1ns/1ps

module ieu_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       in_valid,
   input  ieu_pkg::ieu_op_t           in_op,
   input  logic                       dbus_cmd_ready,
   input  logic                       dbus_valid,
   input  logic [ieu_pkg::DATA_W-1:0] dbus_dout,
   input  logic                       flush_ack,
   output logic                       in_ready,
   output logic                       dbus_cmd_valid,
   output ieu_pkg::dbus_cmd_t         dbus_cmd,
   output logic                       dbus_ready,
   output logic                       regf_we,
   output ieu_pkg::wb_req_t           regf_wr,
   output logic                       specul_flush,
   output logic [ieu_pkg::PC_W-1:0]   flush_tgt,
   output logic                       bpu_wb,
   output logic                       bpu_hit
);
   import ieu_pkg::*;

   logic [DATA_W-1:0] arith_result;
   logic [DATA_W-1:0] logic_result;
   logic              cc;
   logic              accept;
   logic              accept_ok;
   logic              mem_busy;
   logic              mem_wb_valid;
   logic              mem_wb_grant;
   logic              flush_hold;
   wb_req_t           mem_wb;

   // Encodings past the last opcode complete the handshake but do nothing
   assign accept_ok = (in_op.opc <= OPC_JMPFAR);

   ieu_arith u_arith (.clk(clk), .rst_n(rst_n), .op(in_op), .accept(accept),
                      .result(arith_result), .cc(cc));

   ieu_logic u_logic (.op(in_op), .result(logic_result));

   ieu_mem u_mem (.clk(clk), .rst_n(rst_n), .op(in_op), .accept(accept),
                  .dbus_cmd_ready(dbus_cmd_ready), .dbus_valid(dbus_valid),
                  .dbus_dout(dbus_dout), .mem_wb_grant(mem_wb_grant),
                  .dbus_cmd_valid(dbus_cmd_valid), .dbus_cmd(dbus_cmd),
                  .dbus_ready(dbus_ready), .mem_busy(mem_busy),
                  .mem_wb_valid(mem_wb_valid), .mem_wb(mem_wb));

   ieu_branch u_branch (.clk(clk), .rst_n(rst_n), .op(in_op), .accept(accept), .cc(cc),
                        .flush_ack(flush_ack), .specul_flush(specul_flush),
                        .flush_hold(flush_hold), .flush_tgt(flush_tgt),
                        .bpu_wb(bpu_wb), .bpu_hit(bpu_hit));

   ieu_wb_arb u_wb_arb (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .accept_ok(accept_ok),
                        .op(in_op), .arith_result(arith_result), .logic_result(logic_result),
                        .mem_busy(mem_busy), .flush_hold(flush_hold),
                        .mem_wb_valid(mem_wb_valid), .mem_wb(mem_wb), .in_ready(in_ready),
                        .accept(accept), .mem_wb_grant(mem_wb_grant), .regf_we(regf_we),
                        .regf_wr(regf_wr));

endmodule

// File: dv/ieu_tb_ref.svh
// Reference model for the execute stage testbench
// Expected results, bus memory model, xorshift source and register scoreboard
`ifndef IEU_TB_REF_SVH
`define IEU_TB_REF_SVH

logic [31:0] rng_state = 32'd9943;
logic [31:0] exp_data [32];
logic        exp_pend [32];
logic [7:0]  mem_b [logic [31:0]];   // Bytes written by stores

function automatic logic [31:0] xorshift();
   logic [31:0] x;
   x = rng_state;
   x ^= x << 13;
   x ^= x >> 17;
   x ^= x << 5;
   rng_state = x;
   return x;
endfunction

// Unwritten bytes follow a pattern of the whole address
function automatic logic [7:0] byte_at(input logic [31:0] a);
   if (mem_b.exists(a))
      return mem_b[a];
   return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
endfunction

function automatic logic [31:0] read_bus(input logic [31:0] addr, input mem_size_e size);
   logic [31:0] w;
   int          n;
   n = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
   w = '0;
   for (int i = 0; i < n; i++)
      w[8*i +: 8] = byte_at(addr + i);   // Right-aligned
   return w;
endfunction

function automatic logic [31:0] ref_load(input ieu_op_t op);
   logic [31:0] raw;
   raw = read_bus(op.operand_1 + op.operand_2, op.size);
   case (op.size)
      SIZE_BYTE: return {{24{op.sign_ext & raw[7]}}, raw[7:0]};
      SIZE_HALF: return {{16{op.sign_ext & raw[15]}}, raw[15:0]};
      default:   return raw;
   endcase
endfunction

function automatic logic [31:0] ref_alu(input ieu_op_t op);
   logic [4:0] sh;
   sh = op.operand_2[4:0];
   case (op.opc)
      OPC_SUB:     return op.operand_1 - op.operand_2;
      OPC_CMP_EQ:  return {31'b0, op.operand_1 == op.operand_2};
      OPC_CMP_LT:  return {31'b0, $signed(op.operand_1) < $signed(op.operand_2)};
      OPC_CMP_LTU: return {31'b0, op.operand_1 < op.operand_2};
      OPC_AND:     return op.operand_1 & op.operand_2;
      OPC_OR:      return op.operand_1 | op.operand_2;
      OPC_XOR:     return op.operand_1 ^ op.operand_2;
      OPC_SLL:     return op.operand_1 << sh;
      OPC_SRL:     return op.operand_1 >> sh;
      OPC_SRA:     return $signed(op.operand_1) >>> sh;
      OPC_JMPFAR:  return {op.pc + 30'd1, 2'b00};   // Link
      default:     return op.operand_1 + op.operand_2;
   endcase
endfunction

// Mismatch and correct target of a jump
function automatic void ref_branch(input ieu_op_t op, input logic cc,
                                   output logic mis, output logic [29:0] tgt);
   if (op.opc == OPC_JMPREL) begin
      mis = (op.pred_taken != cc);
      tgt = cc ? op.pred_tgt : op.pc + 30'd1;
   end else begin
      tgt = op.operand_1[31:2];
      mis = (op.pred_tgt != tgt);
   end
endfunction

function automatic dbus_cmd_t ref_cmd(input ieu_op_t op);
   dbus_cmd_t c;
   c.addr  = op.operand_1 + op.operand_2;
   c.size  = op.size;
   c.we    = (op.opc == OPC_STORE);
   c.wdata = op.operand_3;
   return c;
endfunction

`endif

// File: dv/ieu_tb.sv
// Execute stage testbench
// Drives random operations, models the data bus and the flush acknowledge,
// and checks every register write against the reference model

`timescale 1ns/1ps

module ieu_tb;
   import ieu_pkg::*;

   logic            clk;
   logic            rst_n;
   logic            in_valid;
   ieu_op_t         in_op;
   logic            in_ready;
   logic            dbus_cmd_ready;
   logic            dbus_valid;
   logic [31:0]     dbus_dout;
   logic            flush_ack;
   logic            dbus_cmd_valid;
   dbus_cmd_t       dbus_cmd;
   logic            dbus_ready;
   logic            regf_we;
   wb_req_t         regf_wr;
   logic            specul_flush;
   logic [29:0]     flush_tgt;
   logic            bpu_wb;
   logic            bpu_hit;
   int              errors = 0;
   int              tests = 0;
   logic            model_cc = 1'b0;
   dbus_cmd_t       exp_cmd;
   logic            last_mis;
   logic [29:0]     last_tgt;
   logic [4:0]      next_reg = 5'd1;

   `include "ieu_tb_ref.svh"

   ieu_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic abort_run(input string what);
      $display("timeout: %s at %0t", what, $time);
      $display("=== FAIL ===");
      $finish;
   endtask

   task automatic end_test(input string name, input int err_before);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "failed");
   endtask

   // Unique destination per operation in flight
   function automatic ieu_op_t rand_op(input ieu_opc_e opc);
      ieu_op_t op;
      op = '0;
      op.opc        = opc;
      op.operand_1  = xorshift();
      op.operand_2  = xorshift();
      op.operand_3  = xorshift();
      op.wb         = 1'b1;
      op.wb_addr    = next_reg;
      op.pc         = 30'(xorshift());
      op.pred_taken = 1'(xorshift());
      op.pred_tgt   = 30'(xorshift());
      op.size       = SIZE_WORD;
      next_reg      = (next_reg == 5'd31) ? 5'd1 : next_reg + 5'd1;
      return op;
   endfunction

   // Starts and ends 2 ns after a rising edge
   task automatic issue(input ieu_op_t op);
      int n;
      in_op    = op;
      in_valid = 1'b1;
      n = 0;
      while (1) begin
         @(posedge clk);
         if (in_ready)
            break;
         n++;
         if (n > 200)
            abort_run("issue never accepted");
      end
      if (op.opc == OPC_JMPREL || op.opc == OPC_JMPFAR) begin
         ref_branch(op, model_cc, last_mis, last_tgt);
         assert (bpu_wb && bpu_hit == !last_mis) else begin
            $display("error at %0t: bpu_hit expected %b got %b (bpu_wb %b)", $time,
                     !last_mis, bpu_hit, bpu_wb);
            errors++;
         end
         assert (specul_flush == last_mis) else begin
            $display("error at %0t: specul_flush expected %b got %b", $time,
                     last_mis, specul_flush);
            errors++;
         end
      end
      if (op.opc == OPC_LOAD || op.opc == OPC_STORE)
         exp_cmd = ref_cmd(op);
      if (op.wb && op.opc != OPC_STORE) begin
         exp_data[op.wb_addr] = (op.opc == OPC_LOAD) ? ref_load(op) : ref_alu(op);
         exp_pend[op.wb_addr] = 1'b1;
      end
      if (op.opc inside {OPC_CMP_EQ, OPC_CMP_LT, OPC_CMP_LTU})
         model_cc = (ref_alu(op) != 32'd0);
      #2 in_valid = 1'b0;
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_pend.sum() with (int'(item)) != 0 || uut.mem_busy) begin
         @(posedge clk);
         #2 n++;
         if (n > 300)
            abort_run("expected register writes missing");
      end
   endtask

   task automatic wait_flush();
      int n;
      n = 0;
      while (1) begin
         @(posedge clk);
         assert (specul_flush && !in_ready && flush_tgt == last_tgt) else begin
            $display("error at %0t: flush_tgt expected %h got %h (flush %b ready %b)",
                     $time, last_tgt, flush_tgt, specul_flush, in_ready);
            errors++;
         end
         if (flush_ack)
            break;
         n++;
         if (n > 50)
            abort_run("flush never acknowledged");
      end
      #2;
   endtask

   // Register write checker
   always @(posedge clk) begin
      if (rst_n && regf_we) begin
         assert (exp_pend[regf_wr.addr]) else begin
            $display("unexpected register write to r%0d at %0t", regf_wr.addr, $time);
            errors++;
         end
         assert (regf_wr.data == exp_data[regf_wr.addr]) else begin
            $display("error at %0t: regf_wr.data r%0d expected %h got %h", $time,
                     regf_wr.addr, exp_data[regf_wr.addr], regf_wr.data);
            errors++;
         end
         exp_pend[regf_wr.addr] = 1'b0;
      end
   end

   // Data bus with random command and response delays
   initial begin
      dbus_cmd_ready = 1'b0;
      dbus_valid     = 1'b0;
      dbus_dout      = '0;
      forever begin
         @(posedge clk);
         if (dbus_cmd_valid) begin
            repeat (xorshift() % 4) @(posedge clk);
            #2 dbus_cmd_ready = 1'b1;
            @(posedge clk);   // Transfer
            assert (dbus_cmd == exp_cmd) else begin
               $display("error at %0t: dbus_cmd expected %h got %h", $time, exp_cmd, dbus_cmd);
               errors++;
            end
            if (dbus_cmd.we) begin
               for (int i = 0; i < (1 << dbus_cmd.size); i++)
                  mem_b[dbus_cmd.addr + i] = dbus_cmd.wdata[8*i +: 8];
            end
            #2 dbus_cmd_ready = 1'b0;
            if (!dbus_cmd.we) begin
               repeat (xorshift() % 4) @(posedge clk);
               #2 dbus_valid = 1'b1;
               dbus_dout = read_bus(dbus_cmd.addr, dbus_cmd.size);
               @(posedge clk);
               assert (dbus_ready) else begin
                  $display("error at %0t: dbus_ready expected 1 got %b", $time, dbus_ready);
                  errors++;
               end
               #2 dbus_valid = 1'b0;
            end
         end
      end
   end

   // Fetch side acknowledges a flush after a few cycles
   initial begin
      flush_ack = 1'b0;
      forever begin
         @(posedge clk);
         if (specul_flush) begin
            repeat (xorshift() % 4) @(posedge clk);
            #2 flush_ack = 1'b1;
            @(posedge clk);
            #2 flush_ack = 1'b0;
         end
      end
   end

   initial begin
      int      e0;
      ieu_op_t op;
      rst_n    = 1'b0;
      in_valid = 1'b0;
      in_op    = '0;
      for (int i = 0; i < 32; i++)
         exp_pend[i] = 1'b0;
      repeat (2) @(posedge clk);
      #2 rst_n = 1'b1;

      e0 = errors;
      assert (in_ready && !dbus_cmd_valid && !dbus_ready && !regf_we && !specul_flush
              && !bpu_wb && !uut.cc) else begin
         $display("control outputs not idle after reset");
         errors++;
      end
      end_test("reset state", e0);

      e0 = errors;
      for (int i = 0; i < 40; i++) begin
         op = rand_op(ieu_opc_e'(xorshift() % 11));
         issue(op);
         @(posedge clk);   // Written one cycle after acceptance
         assert (regf_we && regf_wr.addr == op.wb_addr) else begin
            $display("error at %0t: regf_wr.addr expected %0d got %0d (we %b)", $time,
                     op.wb_addr, regf_wr.addr, regf_we);
            errors++;
         end
         #2;
      end
      end_test("alu results", e0);

      e0 = errors;
      for (int i = 0; i < 16; i++) begin
         op = rand_op(OPC_LOAD);
         op.operand_1 = 32'h1000 + (xorshift() % 64);
         op.operand_2 = xorshift() % 16;
         op.size      = mem_size_e'(xorshift() % 3);
         op.sign_ext  = 1'(xorshift());
         op.wb        = (i != 5);   // One load without destination
         issue(op);
         drain();
      end
      end_test("loads", e0);

      e0 = errors;
      for (int k = 0; k < 4; k++) begin
         op = rand_op(OPC_STORE);
         op.operand_1 = 32'h1000 + 4 * k;
         op.operand_2 = xorshift() % 4;
         op.size      = mem_size_e'(xorshift() % 3);
         issue(op);
         op = rand_op(OPC_LOAD);
         op.operand_1 = 32'h1000 + 4 * k;
         op.operand_2 = 0;
         issue(op);
         for (int i = 0; i < 6; i++)
            issue(rand_op(ieu_opc_e'(xorshift() % 11)));
         drain();
      end
      end_test("stores and collisions", e0);

      e0 = errors;
      for (int i = 0; i < 12; i++) begin
         op = rand_op(ieu_opc_e'(OPC_CMP_EQ + xorshift() % 3));
         op.operand_2 = (i % 3 == 0) ? op.operand_1 : op.operand_2;
         issue(op);
         op = rand_op(OPC_JMPREL);
         op.wb = 1'b0;
         issue(op);
         if (last_mis)
            wait_flush();
         op = rand_op(OPC_JMPFAR);
         op.pred_tgt = (xorshift() & 1) ? op.operand_1[31:2] : op.pred_tgt;
         issue(op);
         if (last_mis)
            wait_flush();
         drain();
      end
      end_test("branch checking", e0);

      $display("%0d tests, %0d errors", tests, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+dv
verilog/ieu_pkg.sv
verilog/ieu_arith.sv
verilog/ieu_logic.sv
verilog/ieu_mem.sv
verilog/ieu_branch.sv
verilog/ieu_wb_arb.sv
verilog/ieu_top.sv
dv/ieu_tb.sv
